// File: Makefile
# Verilator build and run of the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/cpu.sv
/*
 * Four-stage MIPS subset pipeline: fetch, decode, execute, result
 */
`timescale 1ns/100ps

module cpu import cpuPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  logic      run,
	input  logic      imemWrEn,
	input  imemAddr_t imemAddr,
	input  word_t     imemWrData,
	output logic      wbValid,
	output regAddr_t  wbReg,
	output word_t     wbData
);
	logic branchTaken;
	word_t branchTarget;

	logic fetchValid;
	word_t fetchInst;
	word_t fetchPcPlus4;

	// Register file write from the result stage
	logic wrEn;
	regAddr_t wrAddr;
	word_t wrData;

	decodeExecIf decodeExec ();
	execResultIf execResult ();

	fetchStage u_fetch (
		.clk          (clk),
		.rstN         (rstN),
		.run          (run),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.imemWrEn     (imemWrEn),
		.imemAddr     (imemAddr),
		.imemWrData   (imemWrData),
		.fetchValid   (fetchValid),
		.fetchInst    (fetchInst),
		.fetchPcPlus4 (fetchPcPlus4)
	);

	decodeStage u_decode (
		.clk          (clk),
		.rstN         (rstN),
		.fetchValid   (fetchValid),
		.fetchInst    (fetchInst),
		.fetchPcPlus4 (fetchPcPlus4),
		.branchTaken  (branchTaken),
		.wrEn         (wrEn),
		.wrAddr       (wrAddr),
		.wrData       (wrData),
		.out          (decodeExec.decodeStage)
	);

	executeStage u_execute (
		.clk          (clk),
		.rstN         (rstN),
		.in           (decodeExec.executeStage),
		.out          (execResult.executeStage),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget)
	);

	resultStage u_result (
		.clk     (clk),
		.rstN    (rstN),
		.in      (execResult.resultStage),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

endmodule

// File: design/cpuPkg.sv
/*
 * CPU types shared by the pipeline stages and the testbench
 */
`include "cpu_defines.svh"

package cpuPkg;

	// Data word, also used for instructions and addresses
	typedef logic [`WORD_WIDTH-1:0] word_t;

	typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;

	// Word index into instruction memory
	typedef logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr_t;

	typedef logic [2:0] aluCtrl_t;

	// Branch condition tested in execute
	typedef logic [1:0] branchKind_t;

	localparam branchKind_t branchNone = 2'd0;
	localparam branchKind_t branchEq   = 2'd1;
	localparam branchKind_t branchNe   = 2'd2;
	localparam branchKind_t branchGtz  = 2'd3;

endpackage

// File: design/cpu_defines.svh
/*
 * CPU sizes, MIPS opcode and function encodings, and ALU control codes
 */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_WIDTH 32
`define REG_COUNT  32
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Primary opcodes, instruction bits 31:26
`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_BGTZ  6'b000111

// R-type function field, bits 5:0
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_SLL  6'b000000
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

// ALU control, code 4 left free
`define ALU_AND  3'd0
`define ALU_OR   3'd1
`define ALU_ADD  3'd2
`define ALU_SLT  3'd3
`define ALU_SLL  3'd5
`define ALU_SUB  3'd6
`define ALU_SLTU 3'd7

`endif

// File: design/decodeStage.sv
/*
 * Decode stage: control decode, operand read, immediate extension
 * and the decode/execute register
 */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decodeStage import cpuPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     fetchValid,
	input  word_t    fetchInst,
	input  word_t    fetchPcPlus4,
	input  logic     branchTaken,
	input  logic     wrEn,
	input  regAddr_t wrAddr,
	input  word_t    wrData,
	decodeExecIf.decodeStage out
);
	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	logic [4:0] shamt;
	logic [15:0] imm16;

	logic supported;
	aluCtrl_t aluCtrl;
	logic useImm;
	logic signExt;
	logic destIsRd;
	logic regWr;
	logic memWr;
	logic memToReg;
	branchKind_t branch;

	word_t rdDataA;
	word_t rdDataB;
	word_t immExt;

	assign opcode = fetchInst[31:26];
	assign rs = fetchInst[25:21];
	assign rt = fetchInst[20:16];
	assign rd = fetchInst[15:11];
	assign shamt = fetchInst[10:6];
	assign funct = fetchInst[5:0];
	assign imm16 = fetchInst[15:0];

	always_comb begin
		supported = 1'b1;
		aluCtrl = `ALU_ADD;
		useImm = 1'b0;
		signExt = 1'b0;
		destIsRd = 1'b0;
		regWr = 1'b0;
		memWr = 1'b0;
		memToReg = 1'b0;
		branch = branchNone;
		case (opcode)
			`OP_RTYPE: begin
				destIsRd = 1'b1;
				regWr = 1'b1;
				case (funct)
					`FN_ADD, `FN_ADDU: aluCtrl = `ALU_ADD;
					`FN_SUB, `FN_SUBU: aluCtrl = `ALU_SUB;
					`FN_AND:           aluCtrl = `ALU_AND;
					`FN_OR:            aluCtrl = `ALU_OR;
					`FN_SLL:           aluCtrl = `ALU_SLL;
					`FN_SLT:           aluCtrl = `ALU_SLT;
					`FN_SLTU:          aluCtrl = `ALU_SLTU;
					default:           supported = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				useImm = 1'b1;
				signExt = 1'b1;
				regWr = 1'b1;
			end
			`OP_LW: begin
				useImm = 1'b1;
				signExt = 1'b1;
				regWr = 1'b1;
				memToReg = 1'b1;
			end
			`OP_SW: begin
				useImm = 1'b1;
				signExt = 1'b1;
				memWr = 1'b1;
			end
			// Branches compare in execute and use the offset for the target
			`OP_BEQ: begin
				signExt = 1'b1;
				aluCtrl = `ALU_SUB;
				branch = branchEq;
			end
			`OP_BNE: begin
				signExt = 1'b1;
				aluCtrl = `ALU_SUB;
				branch = branchNe;
			end
			`OP_BGTZ: begin
				signExt = 1'b1;
				aluCtrl = `ALU_SUB;
				branch = branchGtz;
			end
			default: supported = 1'b0;
		endcase
	end

	assign immExt = signExt ? {{(`WORD_WIDTH-16){imm16[15]}}, imm16}
	                        : {{(`WORD_WIDTH-16){1'b0}}, imm16};

	regFile u_regFile (
		.clk     (clk),
		.rstN    (rstN),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.rdAddrA (rs),
		.rdAddrB (rt),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB)
	);

	// Decode/execute control, unsupported encodings become bubbles
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			out.valid <= 1'b0;
			out.regWr <= 1'b0;
			out.memWr <= 1'b0;
			out.branch <= branchNone;
		end else begin
			out.valid <= fetchValid && supported && !branchTaken;
			out.regWr <= regWr;
			out.memWr <= memWr;
			out.branch <= branch;
		end
	end

	always_ff @(posedge clk) begin
		out.aluCtrl <= aluCtrl;
		out.operandA <= rdDataA;
		out.operandB <= rdDataB;
		out.imm <= immExt;
		out.useImm <= useImm;
		out.shamt <= shamt;
		out.dest <= destIsRd ? rd : rt;
		out.memToReg <= memToReg;
		out.pcPlus4 <= fetchPcPlus4;
	end

endmodule

// File: design/executeStage.sv
/*
 * Execute stage: ALU, branch resolution and the execute/result register
 */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module executeStage import cpuPkg::*; (
	input  logic  clk,
	input  logic  rstN,
	decodeExecIf.executeStage in,
	execResultIf.executeStage out,
	output logic  branchTaken,
	output word_t branchTarget
);
	word_t aluB;
	word_t aluResult;
	logic condMet;

	assign aluB = in.useImm ? in.imm : in.operandB;

	always_comb begin
		case (in.aluCtrl)
			`ALU_AND:  aluResult = in.operandA & aluB;
			`ALU_OR:   aluResult = in.operandA | aluB;
			`ALU_ADD:  aluResult = in.operandA + aluB;
			`ALU_SLT:  aluResult = word_t'($signed(in.operandA) < $signed(aluB));
			// sll shifts rt, which arrives as the second operand
			`ALU_SLL:  aluResult = aluB << in.shamt;
			`ALU_SUB:  aluResult = in.operandA - aluB;
			`ALU_SLTU: aluResult = word_t'(in.operandA < aluB);
			default:   aluResult = '0;
		endcase
	end

	// Branch conditions
	always_comb begin
		case (in.branch)
			branchEq:  condMet = (in.operandA == in.operandB);
			branchNe:  condMet = (in.operandA != in.operandB);
			branchGtz: condMet = ($signed(in.operandA) > 0);
			default:   condMet = 1'b0;
		endcase
	end

	assign branchTaken = in.valid && condMet;
	assign branchTarget = in.pcPlus4 + (in.imm << 2);

	// Branches retire here and do not reach the result stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			out.valid <= 1'b0;
			out.regWr <= 1'b0;
			out.memWr <= 1'b0;
		end else begin
			out.valid <= in.valid && (in.branch == branchNone);
			out.regWr <= in.regWr;
			out.memWr <= in.memWr;
		end
	end

	always_ff @(posedge clk) begin
		out.aluOut <= aluResult;
		out.storeData <= in.operandB;
		out.dest <= in.dest;
		out.memToReg <= in.memToReg;
	end

endmodule

// File: design/fetchStage.sv
/*
 * Fetch stage: program counter, instruction memory with its load port,
 * and the fetch/decode register
 */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetchStage import cpuPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  logic      run,
	input  logic      branchTaken,
	input  word_t     branchTarget,
	input  logic      imemWrEn,
	input  imemAddr_t imemAddr,
	input  word_t     imemWrData,
	output logic      fetchValid,
	output word_t     fetchInst,
	output word_t     fetchPcPlus4
);
	localparam int idxWidth = $bits(imemAddr_t);

	word_t imem [`IMEM_DEPTH];
	word_t pc;
	word_t pcPlus4;
	imemAddr_t pcIdx;

	assign pcPlus4 = pc + 4;
	// Word index, byte offset dropped
	assign pcIdx = pc[idxWidth+1:2];

	// Program load port
	always_ff @(posedge clk) begin
		if (imemWrEn) begin
			imem[imemAddr] <= imemWrData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			fetchValid <= 1'b0;
		end else if (!run) begin
			// Held at address zero until started
			pc <= '0;
			fetchValid <= 1'b0;
		end else begin
			pc <= branchTaken ? branchTarget : pcPlus4;
			// Younger instruction behind a taken branch is dropped
			fetchValid <= !branchTaken;
		end
	end

	// Fetch/decode payload
	always_ff @(posedge clk) begin
		fetchInst <= imem[pcIdx];
		fetchPcPlus4 <= pcPlus4;
	end

endmodule

// File: design/pipeIf.sv
/*
 * Stage boundary bundles: decode to execute, and execute to result
 */
`timescale 1ns/100ps

interface decodeExecIf import cpuPkg::*;;
	logic        valid;
	aluCtrl_t    aluCtrl;
	word_t       operandA;
	word_t       operandB;
	word_t       imm;
	logic        useImm;
	logic [4:0]  shamt;
	regAddr_t    dest;
	logic        regWr;
	logic        memWr;
	logic        memToReg;
	branchKind_t branch;
	word_t       pcPlus4;

	modport decodeStage (
		output valid, aluCtrl, operandA, operandB, imm, useImm, shamt,
		output dest, regWr, memWr, memToReg, branch, pcPlus4
	);

	modport executeStage (
		input valid, aluCtrl, operandA, operandB, imm, useImm, shamt,
		input dest, regWr, memWr, memToReg, branch, pcPlus4
	);
endinterface

interface execResultIf import cpuPkg::*;;
	logic     valid;
	word_t    aluOut;
	word_t    storeData;
	regAddr_t dest;
	logic     regWr;
	logic     memWr;
	logic     memToReg;

	modport executeStage (output valid, aluOut, storeData, dest, regWr, memWr, memToReg);

	modport resultStage (input valid, aluOut, storeData, dest, regWr, memWr, memToReg);
endinterface

// File: design/regFile.sv
/*
 * Register file: 32 words, two combinational read ports, one write port
 */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module regFile import cpuPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     wrEn,
	input  regAddr_t wrAddr,
	input  word_t    wrData,
	input  regAddr_t rdAddrA,
	input  regAddr_t rdAddrB,
	output word_t    rdDataA,
	output word_t    rdDataB
);
	word_t regs [`REG_COUNT];
	logic wrLive;

	// Writes to register zero are dropped
	assign wrLive = wrEn && (wrAddr != '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-before-read bypass
	assign rdDataA = (wrLive && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrLive && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

// File: design/resultStage.sv
/*
 * Result stage: data memory, writeback select and the writeback strobe
 */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module resultStage import cpuPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	execResultIf.resultStage in,
	output logic     wrEn,
	output regAddr_t wrAddr,
	output word_t    wrData,
	output logic     wbValid,
	output regAddr_t wbReg,
	output word_t    wbData
);
	localparam int dmemIdxWidth = $clog2(`DMEM_DEPTH);

	word_t dmem [`DMEM_DEPTH];
	logic [dmemIdxWidth-1:0] dmemIdx;
	word_t loadData;
	logic storeEn;

	// Word addressed, byte offset ignored
	assign dmemIdx = in.aluOut[dmemIdxWidth+1:2];

	// No stores land while the core is held in reset
	assign storeEn = rstN && in.valid && in.memWr;

	always_ff @(posedge clk) begin
		if (storeEn) begin
			dmem[dmemIdx] <= in.storeData;
		end
	end

	assign loadData = dmem[dmemIdx];

	// Register writes to r0 never strobe
	assign wrEn = in.valid && in.regWr && (in.dest != '0);
	assign wrAddr = in.dest;
	assign wrData = in.memToReg ? loadData : in.aluOut;

	assign wbValid = wrEn;
	assign wbReg = wrAddr;
	assign wbData = wrData;

endmodule

// File: sim/cpuTb.sv
/*
 * Directed testbench for the cpu: loads programs, runs them and
 * compares the writeback strobes with expected results
 */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuTb import cpuPkg::*; ();
	localparam int resetCycles = 10;
	localparam int runCycles = 80;
	// Six tests of at most 40 load and 80 run cycles, with margin
	localparam int cycleLimit = 2000;
	localparam word_t nop = '0;

	logic clk;
	logic rstN;
	logic run;
	logic imemWrEn;
	imemAddr_t imemAddr;
	word_t imemWrData;
	logic wbValid;
	regAddr_t wbReg;
	word_t wbData;

	int seed = 32'h4a2a;
	int errorCount = 0;
	int cycleCount = 0;

	word_t prog[$];
	word_t expReg[$];
	word_t expData[$];
	word_t gotReg[$];
	word_t gotData[$];

	cpu u_cpu (
		.clk        (clk),
		.rstN       (rstN),
		.run        (run),
		.imemWrEn   (imemWrEn),
		.imemAddr   (imemAddr),
		.imemWrData (imemWrData),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Strobes are stable by the falling edge
	always @(negedge clk) begin
		if (rstN && wbValid) begin
			gotReg.push_back(word_t'(wbReg));
			gotData.push_back(wbData);
		end
	end

	task automatic stopOnError();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			stopOnError();
		end
	end

	task automatic checkValue(input string testName, input string what,
	                          input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errorCount++;
			$display("Error: %s %s expected 0x%08h actual 0x%08h",
			         testName, what, expected, actual);
			stopOnError();
		end
	endtask

	function automatic word_t rType(input int rs, input int rt, input int rd,
	                                input int sh, input logic [5:0] fn);
		return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic word_t iType(input logic [5:0] op, input int rs, input int rt,
	                                input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic word_t signExtend(input int v);
		logic [15:0] h;
		h = 16'(v);
		return {{16{h[15]}}, h};
	endfunction

	task automatic expectWb(input int r, input word_t v);
		expReg.push_back(word_t'(r));
		expData.push_back(v);
	endtask

	task automatic applyReset();
		@(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		imemWrEn = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
	endtask

	// Writes the program with run low, then starts the core
	task automatic loadProgram();
		foreach (prog[i]) begin
			@(negedge clk);
			imemWrEn = 1'b1;
			imemAddr = imemAddr_t'(i);
			imemWrData = prog[i];
		end
		@(negedge clk);
		imemWrEn = 1'b0;
		gotReg.delete();
		gotData.delete();
		run = 1'b1;
	endtask

	task automatic runProgram(input string testName);
		int waited;
		// Branch to itself parks the core after the last instruction
		prog.push_back(iType(`OP_BEQ, 0, 0, -1));
		loadProgram();
		waited = 0;
		while (gotReg.size() < expReg.size() && waited < runCycles) begin
			@(negedge clk);
			waited++;
		end
		if (gotReg.size() < expReg.size()) begin
			errorCount++;
			$display("%s: only %0d of %0d writeback strobes arrived",
			         testName, gotReg.size(), expReg.size());
			stopOnError();
		end
		repeat (8) @(negedge clk);
		checkValue(testName, "strobe count", expReg.size(), gotReg.size());
		foreach (expReg[i]) begin
			checkValue(testName, $sformatf("strobe %0d register", i), expReg[i], gotReg[i]);
			checkValue(testName, $sformatf("strobe %0d data", i), expData[i], gotData[i]);
		end
		run = 1'b0;
		repeat (4) @(negedge clk);
		prog.delete();
		expReg.delete();
		expData.delete();
	endtask

	task automatic aluOps();
		int ra;
		int rb;
		word_t a;
		word_t b;
		ra = $random(seed);
		rb = $random(seed);
		a = signExtend(ra);
		b = signExtend(rb);
		prog.push_back(iType(`OP_ADDI, 0, 1, ra));
		prog.push_back(iType(`OP_ADDI, 0, 2, rb));
		prog.push_back(nop);
		prog.push_back(rType(1, 2, 3, 0, `FN_ADD));
		prog.push_back(rType(1, 2, 4, 0, `FN_ADDU));
		prog.push_back(rType(1, 2, 5, 0, `FN_SUB));
		prog.push_back(rType(1, 2, 6, 0, `FN_SUBU));
		prog.push_back(rType(1, 2, 7, 0, `FN_AND));
		prog.push_back(rType(1, 2, 8, 0, `FN_OR));
		expectWb(1, a);
		expectWb(2, b);
		expectWb(3, a + b);
		expectWb(4, a + b);
		expectWb(5, a - b);
		expectWb(6, a - b);
		expectWb(7, a & b);
		expectWb(8, a | b);
		runProgram("aluOps");
	endtask

	task automatic shiftCompare();
		word_t a;
		word_t b;
		a = signExtend(-5);
		b = signExtend(3);
		prog.push_back(iType(`OP_ADDI, 0, 1, -5));
		prog.push_back(iType(`OP_ADDI, 0, 2, 3));
		prog.push_back(nop);
		prog.push_back(rType(0, 2, 3, 1, `FN_SLL));
		prog.push_back(rType(0, 2, 4, 4, `FN_SLL));
		prog.push_back(rType(0, 1, 5, 31, `FN_SLL));
		prog.push_back(rType(0, 1, 6, 0, `FN_SLL));
		prog.push_back(rType(1, 2, 7, 0, `FN_SLT));
		prog.push_back(rType(1, 2, 8, 0, `FN_SLTU));
		prog.push_back(rType(2, 1, 9, 0, `FN_SLT));
		prog.push_back(rType(2, 1, 10, 0, `FN_SLTU));
		expectWb(1, a);
		expectWb(2, b);
		expectWb(3, b << 1);
		expectWb(4, b << 4);
		expectWb(5, a << 31);
		expectWb(6, a);
		// Signed and unsigned order disagree for these operands
		// -5 is below 3 signed, but 0xfffffffb is above 3 unsigned
		expectWb(7, 32'd1);
		expectWb(8, 32'd0);
		expectWb(9, 32'd0);
		expectWb(10, 32'd1);
		runProgram("shiftCompare");
	endtask

	task automatic memRoundTrip();
		int v[3];
		foreach (v[i]) begin
			v[i] = $random(seed);
		end
		prog.push_back(iType(`OP_ADDI, 0, 1, 64));
		prog.push_back(iType(`OP_ADDI, 0, 2, v[0]));
		prog.push_back(iType(`OP_ADDI, 0, 3, v[1]));
		prog.push_back(iType(`OP_ADDI, 0, 4, v[2]));
		prog.push_back(iType(`OP_SW, 1, 2, 0));
		prog.push_back(iType(`OP_SW, 1, 3, -8));
		prog.push_back(iType(`OP_SW, 1, 4, 12));
		prog.push_back(iType(`OP_LW, 1, 5, 0));
		prog.push_back(iType(`OP_LW, 1, 6, -8));
		prog.push_back(iType(`OP_LW, 1, 7, 12));
		expectWb(1, 32'd64);
		expectWb(2, signExtend(v[0]));
		expectWb(3, signExtend(v[1]));
		expectWb(4, signExtend(v[2]));
		expectWb(5, signExtend(v[0]));
		expectWb(6, signExtend(v[1]));
		expectWb(7, signExtend(v[2]));
		runProgram("memRoundTrip");
	endtask

	// Instructions writing r10 sit in squashed slots and must not strobe
	task automatic branchPaths();
		prog.push_back(iType(`OP_ADDI, 0, 1, 5));
		prog.push_back(iType(`OP_ADDI, 0, 2, 5));
		prog.push_back(iType(`OP_ADDI, 0, 3, -3));
		prog.push_back(iType(`OP_ADDI, 0, 4, 0));
		prog.push_back(nop);
		prog.push_back(iType(`OP_BEQ, 1, 2, 2));
		prog.push_back(iType(`OP_ADDI, 0, 10, 1));
		prog.push_back(iType(`OP_ADDI, 0, 10, 2));
		prog.push_back(iType(`OP_ADDI, 0, 11, 8));
		prog.push_back(iType(`OP_BNE, 1, 2, 2));
		prog.push_back(iType(`OP_ADDI, 0, 12, 10));
		prog.push_back(iType(`OP_BGTZ, 1, 0, 2));
		prog.push_back(iType(`OP_ADDI, 0, 10, 3));
		prog.push_back(iType(`OP_ADDI, 0, 10, 4));
		prog.push_back(iType(`OP_ADDI, 0, 13, 14));
		prog.push_back(iType(`OP_BGTZ, 4, 0, 1));
		prog.push_back(iType(`OP_ADDI, 0, 14, 16));
		prog.push_back(iType(`OP_BGTZ, 3, 0, 1));
		prog.push_back(iType(`OP_ADDI, 0, 15, 18));
		prog.push_back(iType(`OP_BEQ, 1, 3, 1));
		prog.push_back(iType(`OP_ADDI, 0, 16, 20));
		prog.push_back(iType(`OP_BNE, 1, 3, 2));
		prog.push_back(iType(`OP_ADDI, 0, 10, 5));
		prog.push_back(iType(`OP_ADDI, 0, 10, 6));
		prog.push_back(iType(`OP_ADDI, 0, 17, 24));
		expectWb(1, 32'd5);
		expectWb(2, 32'd5);
		expectWb(3, signExtend(-3));
		expectWb(4, 32'd0);
		expectWb(11, 32'd8);
		expectWb(12, 32'd10);
		expectWb(13, 32'd14);
		expectWb(14, 32'd16);
		expectWb(15, 32'd18);
		expectWb(16, 32'd20);
		expectWb(17, 32'd24);
		runProgram("branchPaths");
	endtask

	task automatic zeroRegister();
		int r;
		r = $random(seed);
		prog.push_back(iType(`OP_ADDI, 0, 0, 77));
		prog.push_back(iType(`OP_ADDI, 0, 1, r));
		prog.push_back(nop);
		prog.push_back(rType(1, 0, 2, 0, `FN_ADD));
		prog.push_back(rType(0, 1, 3, 0, `FN_ADD));
		expectWb(1, signExtend(r));
		expectWb(2, signExtend(r));
		expectWb(3, signExtend(r));
		runProgram("zeroRegister");
	endtask

	task automatic runAndReset();
		int r;
		r = $random(seed);
		applyReset();
		gotReg.delete();
		gotData.delete();
		repeat (20) @(negedge clk);
		checkValue("runAndReset", "strobes with run low", 32'd0, gotReg.size());
		// r13 held 14 before reset and must read back as zero
		prog.push_back(iType(`OP_ADDI, 0, 5, r));
		prog.push_back(rType(13, 0, 6, 0, `FN_ADD));
		expectWb(5, signExtend(r));
		expectWb(6, 32'd0);
		runProgram("runAndReset");
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		imemWrEn = 1'b0;
		imemAddr = '0;
		imemWrData = '0;
		applyReset();
		aluOps();
		shiftCompare();
		memRoundTrip();
		branchPaths();
		zeroRegister();
		runAndReset();
		if (errorCount == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stopOnError();
		end
	end

endmodule

// File: sim/cpu_properties.sv
/*
 * Pipeline rules for the cpu, bound to the top level
 */
`timescale 1ns/100ps

module cpuProperties import cpuPkg::*; (
	input logic     clk,
	input logic     rstN,
	input logic     wbValid,
	input regAddr_t wbReg,
	input logic     branchTaken,
	input logic     decValid
);
	// Register zero never strobes
	assert property (@(posedge clk) disable iff (!rstN) wbValid |-> (wbReg != '0))
		else $error("writeback strobe with register zero");

	assert property (@(posedge clk) !rstN |-> !wbValid)
		else $error("writeback strobe during reset");

	// Taken branch squashes the instruction in decode
	assert property (@(posedge clk) disable iff (!rstN) branchTaken |=> !decValid)
		else $error("decode/execute valid after a taken branch");

endmodule

bind cpu cpuProperties u_props (
	.clk         (clk),
	.rstN        (rstN),
	.wbValid     (wbValid),
	.wbReg       (wbReg),
	.branchTaken (branchTaken),
	.decValid    (decodeExec.valid)
);

// File: src.f
+incdir+design
design/cpuPkg.sv
design/pipeIf.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/cpu.sv
sim/cpu_properties.sv
sim/cpuTb.sv
